// File: verilog/dotGenPkg.sv
`default_nettype none

package dotGenPkg;

    // ------------------------------------------------------------------
    // pixel and coordinate widths
    // ------------------------------------------------------------------

    // one RGB dot, 8 bits per channel
    typedef logic [23:0] pixelT;

    // screen coordinate, wide enough for x and y alike
    typedef logic [11:0] coordT;

    // fifo entry: bit 24 flags the last dot of a frame
    typedef logic [24:0] fifoWordT;

    // ------------------------------------------------------------------
    // scan-out FSM
    // ------------------------------------------------------------------

    // IDLE   no tick this cycle
    // SHOW   tick with data, dot on the output
    // STARVE tick found the fifo empty
    typedef enum logic [1:0] {
        IDLE,
        SHOW,
        STARVE
    } scanStateT;

    // ------------------------------------------------------------------
    // colours
    // ------------------------------------------------------------------

    // royal blue, square colour at frame 0
    localparam pixelT SQUARE_BASE = 24'h4169E1;

endpackage

`default_nettype wire

// File: verilog/scanPosGen.sv
`timescale 1ns/1ps
`default_nettype none

module scanPosGen #(
    parameter int pHdisplay = 640,
    parameter int pVdisplay = 480
)(
    input  logic            iSysClk,
    input  logic            rstN,
    input  logic            step,
    output dotGenPkg::coordT xPos,
    output dotGenPkg::coordT yPos,
    output logic            frameEnd
);

    import dotGenPkg::*;

    // last column / last row of the frame
    localparam coordT lpXLast = coordT'(pHdisplay - 1);
    localparam coordT lpYLast = coordT'(pVdisplay - 1);

    logic xWrap;
    logic yWrap;

    assign xWrap = (xPos == lpXLast);
    assign yWrap = (yPos == lpYLast);

    // high while sitting on the bottom right dot
    assign frameEnd = xWrap && yWrap;

    // ------------------------------------------------------------------
    // raster walk, one dot per step
    // ------------------------------------------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            xPos <= '0;
            yPos <= '0;
        end
        else if (step)
        begin
            if (xWrap)
            begin
                xPos <= '0;
                // row advances only at end of line
                yPos <= yWrap ? coordT'(0) : yPos + coordT'(1);
            end
            else
            begin
                xPos <= xPos + coordT'(1);
            end
        end
    end

    // column never leaves the visible area
    xInRange : assert property (@(posedge iSysClk) disable iff (!rstN)
        xPos < coordT'(pHdisplay));

endmodule

`default_nettype wire

// File: verilog/dotPainter.sv
`timescale 1ns/1ps
`default_nettype none

module dotPainter #(
    parameter int pSqX0     = 30,
    parameter int pSqX1     = 100,
    parameter int pSqY0     = 30,
    parameter int pSqY1     = 100,
    parameter int pFrameDiv = 60
)(
    input  logic               iSysClk,
    input  logic               rstN,
    input  logic               step,
    input  dotGenPkg::coordT    xPos,
    input  dotGenPkg::coordT    yPos,
    input  logic               frameEnd,
    output logic               wrEn,
    output dotGenPkg::fifoWordT wrData
);

    import dotGenPkg::*;

    // frame counter width of at least one bit
    localparam int lpCntW = (pFrameDiv > 1) ? $clog2(pFrameDiv) : 1;
    localparam logic [lpCntW-1:0] lpCntLast = lpCntW'(pFrameDiv - 1);

    logic              inSquare;
    logic [lpCntW-1:0] frameCnt;
    pixelT             sqColour;
    pixelT             dotColour;

    // ------------------------------------------------------------------
    // square hit test with inclusive bounds
    // ------------------------------------------------------------------
    assign inSquare = (xPos >= coordT'(pSqX0)) && (xPos <= coordT'(pSqX1)) &&
                      (yPos >= coordT'(pSqY0)) && (yPos <= coordT'(pSqY1));

    // black everywhere else
    assign dotColour = inSquare ? sqColour : pixelT'(0);

    // ------------------------------------------------------------------
    // frame divider and colour flip
    // ------------------------------------------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            frameCnt <= '0;
            sqColour <= SQUARE_BASE;
        end
        else if (step && frameEnd)
        begin
            // last dot of frame just went out
            if (frameCnt == lpCntLast)
            begin
                frameCnt <= '0;
                sqColour <= ~sqColour;
            end
            else
            begin
                frameCnt <= frameCnt + 1'b1;
            end
        end
    end

    // write strobe follows step by one clock
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
            wrEn <= 1'b0;
        else
            wrEn <= step;
    end

    // tagged dot captured with the stepped position
    always_ff @(posedge iSysClk)
    begin
        if (step)
            wrData <= {frameEnd, dotColour};
    end

    // a stepped frame end moves the raster off the last dot
    frameEndDrops : assert property (@(posedge iSysClk) disable iff (!rstN)
        step && frameEnd |=> !frameEnd);

endmodule

`default_nettype wire

// File: verilog/pixelFifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixelFifo #(
    parameter int pFifoDepth = 16
)(
    input  logic               iSysClk,
    input  logic               rstN,
    input  logic               wrEn,
    input  dotGenPkg::fifoWordT wrData,
    input  logic               pop,
    output dotGenPkg::fifoWordT rdData,
    output logic               empty,
    output logic               almostFull
);

    import dotGenPkg::*;

    localparam int lpAw = $clog2(pFifoDepth);

    fifoWordT        mem [pFifoDepth];
    logic [lpAw-1:0] wrPtr;
    logic [lpAw-1:0] rdPtr;
    logic [lpAw:0]   count;
    logic            full;

    // ------------------------------------------------------------------
    // status levels
    // ------------------------------------------------------------------
    assign empty = (count == '0);
    assign full  = (count == (lpAw+1)'(pFifoDepth));

    // one slot or less left, room for the write in flight
    assign almostFull = (count >= (lpAw+1)'(pFifoDepth - 1));

    // head always visible
    assign rdData = mem[rdPtr];

    // storage, no reset on the array
    always_ff @(posedge iSysClk)
    begin
        if (wrEn)
            mem[wrPtr] <= wrData;
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (wrEn)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            // occupancy, simultaneous push and pop cancel
            case ({wrEn, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // gate upstream must keep writes off a full fifo
    noOverflow : assert property (@(posedge iSysClk) disable iff (!rstN)
        full |-> !wrEn);

    // consumer only pops what is there
    noUnderflow : assert property (@(posedge iSysClk) disable iff (!rstN)
        empty |-> !pop);

endmodule

`default_nettype wire

// File: verilog/scanOut.sv
`timescale 1ns/1ps
`default_nettype none

module scanOut (
    input  logic               iSysClk,
    input  logic               rstN,
    input  logic               pixTick,
    input  dotGenPkg::fifoWordT rdData,
    input  logic               empty,
    output logic               pop,
    output dotGenPkg::pixelT    pixel,
    output logic               vd,
    output logic               fe,
    output logic               underrun
);

    import dotGenPkg::*;

    scanStateT state;
    scanStateT stateNext;
    logic      tagQ;

    // take the head on a tick when there is one
    assign pop = pixTick && !empty;

    // ------------------------------------------------------------------
    // next state, decided by this cycle's tick only
    // ------------------------------------------------------------------
    always_comb
    begin
        if (!pixTick)
            stateNext = IDLE;
        else if (empty)
            stateNext = STARVE;
        else
            stateNext = SHOW;
    end

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
            state <= IDLE;
        else
            state <= stateNext;
    end

    // dot and its frame tag, held until the next pop
    always_ff @(posedge iSysClk)
    begin
        if (pop)
        begin
            pixel <= rdData[23:0];
            tagQ  <= rdData[24];
        end
    end

    // outputs decoded from the state register
    assign vd       = (state == SHOW);
    assign underrun = (state == STARVE);
    // frame end rides on the valid cycle only
    assign fe       = vd && tagQ;

endmodule

`default_nettype wire

// File: verilog/dotGenTop.sv
`timescale 1ns/1ps
`default_nettype none

module dotGenTop #(
    parameter int pHdisplay  = 640,
    parameter int pVdisplay  = 480,
    parameter int pSqX0      = 30,
    parameter int pSqX1      = 100,
    parameter int pSqY0      = 30,
    parameter int pSqY1      = 100,
    parameter int pFrameDiv  = 60,
    parameter int pFifoDepth = 16
)(
    input  logic            iSysClk,
    input  logic            rstN,
    input  logic            run,
    input  logic            pixTick,
    output dotGenPkg::pixelT pixel,
    output logic            vd,
    output logic            fe,
    output logic            underrun
);

    import dotGenPkg::*;

    coordT    xPos;
    coordT    yPos;
    logic     frameEnd;
    logic     step;
    logic     wrEn;
    fifoWordT wrData;
    fifoWordT rdData;
    logic     empty;
    logic     almostFull;
    logic     pop;

    // advance only while enabled and the fifo has room
    assign step = run && !almostFull;

    // ------------------------------------------------------------------
    // producer
    // ------------------------------------------------------------------
    scanPosGen #(
        .pHdisplay (pHdisplay),
        .pVdisplay (pVdisplay)
    ) scanPosGen_i (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .step     (step),
        .xPos     (xPos),
        .yPos     (yPos),
        .frameEnd (frameEnd)
    );

    dotPainter #(
        .pSqX0     (pSqX0),
        .pSqX1     (pSqX1),
        .pSqY0     (pSqY0),
        .pSqY1     (pSqY1),
        .pFrameDiv (pFrameDiv)
    ) dotPainter_i (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .step     (step),
        .xPos     (xPos),
        .yPos     (yPos),
        .frameEnd (frameEnd),
        .wrEn     (wrEn),
        .wrData   (wrData)
    );

    // ------------------------------------------------------------------
    // buffer and consumer
    // ------------------------------------------------------------------
    pixelFifo #(
        .pFifoDepth (pFifoDepth)
    ) pixelFifo_i (
        .iSysClk    (iSysClk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .wrData     (wrData),
        .pop        (pop),
        .rdData     (rdData),
        .empty      (empty),
        .almostFull (almostFull)
    );

    scanOut scanOut_i (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .pixTick  (pixTick),
        .rdData   (rdData),
        .empty    (empty),
        .pop      (pop),
        .pixel    (pixel),
        .vd       (vd),
        .fe       (fe),
        .underrun (underrun)
    );

endmodule

`default_nettype wire

// File: verif/dotGenTb.sv
`timescale 1ns/1ps
`default_nettype none

module dotGenTb;

    import dotGenPkg::*;

    localparam int lpH = 16;
    localparam int lpV = 8;
    localparam int lpX0 = 4;
    localparam int lpX1 = 9;
    localparam int lpY0 = 2;
    localparam int lpY1 = 5;
    localparam int lpDiv = 4;
    localparam int lpFrame = lpH * lpV;
    // dots consumed by tests 2 to 5
    localparam int lpTotalPix = 2 * lpFrame + 7 * lpFrame + 160 + 64;

    logic  iSysClk;
    logic  rstN;
    logic  run;
    logic  pixTick;
    pixelT pixel;
    logic  vd;
    logic  fe;
    logic  underrun;

    // reference model state and counters
    int          mx = 0;
    int          my = 0;
    int          mFrame = 0;
    int          pixCount = 0;
    int          underCount = 0;
    int          feCount = 0;
    int          errCount = 0;
    int          checkCount = 0;
    logic [31:0] lcgState = 32'd67;
    pixelT       sqSeen [0:15];
    // tick as sampled by the next rising edge
    logic        tickQ = 1'b0;

    dotGenTop #(
        .pHdisplay  (lpH),
        .pVdisplay  (lpV),
        .pSqX0      (lpX0),
        .pSqX1      (lpX1),
        .pSqY0      (lpY0),
        .pSqY1      (lpY1),
        .pFrameDiv  (lpDiv),
        .pFifoDepth (8)
    ) dut_i (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .run      (run),
        .pixTick  (pixTick),
        .pixel    (pixel),
        .vd       (vd),
        .fe       (fe),
        .underrun (underrun)
    );

    // 4 ns clock
    initial
    begin
        iSysClk = 1'b0;
        forever #2 iSysClk = ~iSysClk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // square colour flips every lpDiv finished frames
    function automatic pixelT expPixel(input int x, input int y, input int frame);
        pixelT colour;
        colour = ((frame / lpDiv) % 2 == 1) ? ~SQUARE_BASE : SQUARE_BASE;
        if (x >= lpX0 && x <= lpX1 && y >= lpY0 && y <= lpY1)
            return colour;
        // black outside the square
        return '0;
    endfunction

    task automatic waitPixels(input int n);
        int target;
        int cycles;
        target = pixCount + n;
        cycles = 0;
        while (pixCount < target && cycles < n * 20)
        begin
            @(posedge iSysClk);
            cycles++;
        end
        if (pixCount < target)
        begin
            errCount++;
            $display("timed out at %0d ns waiting for %0d dots", $time, n);
        end
    endtask

    // ------------------------------------------------------------------
    // monitor sampled on the falling edge
    // ------------------------------------------------------------------
    always @(negedge iSysClk)
    begin
        if (rstN)
        begin
            // each tick answers one clock later with a dot or an underrun
            checkEq(32'(vd || underrun), 32'(tickQ), "tick to output latency");
        end
        if (rstN && vd)
        begin
            checkEq(32'(pixel), 32'(expPixel(mx, my, mFrame)), "dot colour");
            checkEq(32'(fe), 32'(mx == lpH - 1 && my == lpV - 1), "frame end tag");
            if (mx == lpX0 && my == lpY0 && mFrame < 16)
                sqSeen[mFrame] = pixel;
            pixCount++;
            // raster walk of the model
            if (mx == lpH - 1)
            begin
                mx = 0;
                if (my == lpV - 1)
                begin
                    my = 0;
                    mFrame++;
                end
                else
                    my++;
            end
            else
                mx++;
        end
        if (rstN && underrun)
            underCount++;
        if (rstN && fe)
            feCount++;
        tickQ = pixTick;
    end

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic testReset();
        repeat (4)
        begin
            @(negedge iSysClk);
            checkEq(32'(vd), 0, "vd in reset");
            checkEq(32'(fe), 0, "fe in reset");
            checkEq(32'(underrun), 0, "underrun in reset");
        end
        @(posedge iSysClk);
        rstN <= 1'b1;
        // run still low so nothing may move
        repeat (6)
        begin
            @(negedge iSysClk);
            checkEq(32'(vd), 0, "vd after reset");
            checkEq(32'(fe), 0, "fe after reset");
            checkEq(32'(underrun), 0, "underrun after reset");
        end
    endtask

    task automatic testFrames();
        int under0;
        int fe0;
        @(posedge iSysClk);
        run <= 1'b1;
        // let the fifo fill before ticking
        repeat (12) @(posedge iSysClk);
        under0 = underCount;
        fe0 = feCount;
        pixTick <= 1'b1;
        waitPixels(2 * lpFrame);
        checkEq(32'(feCount - fe0), 2, "frame end pulses in two frames");
        checkEq(32'(underCount - under0), 0, "underrun with full fifo");
    endtask

    task automatic testToggle();
        pixelT exp;
        waitPixels(9 * lpFrame - pixCount);
        for (int f = 0; f < 9; f++)
        begin
            exp = (f >= 4 && f < 8) ? ~SQUARE_BASE : SQUARE_BASE;
            checkEq(32'(sqSeen[f]), 32'(exp), $sformatf("square colour frame %0d", f));
        end
    endtask

    task automatic testBackPressure();
        int under0;
        int vd0;
        int target;
        int cycles;
        under0 = underCount;
        @(posedge iSysClk);
        pixTick <= 1'b0;
        repeat (2) @(posedge iSysClk);
        vd0 = pixCount;
        repeat (48) @(posedge iSysClk);
        checkEq(32'(pixCount - vd0), 0, "dots while ticks stopped");
        // random tick gaps
        target = pixCount + 160;
        cycles = 0;
        while (pixCount < target && cycles < 160 * 20)
        begin
            @(posedge iSysClk);
            lcgState = lcgNext(lcgState);
            pixTick <= lcgState[16];
            cycles++;
        end
        if (pixCount < target)
        begin
            errCount++;
            $display("timed out at %0d ns in random tick phase", $time);
        end
        checkEq(32'(underCount - under0), 0, "underrun under back-pressure");
    endtask

    task automatic testUnderrun();
        int under0;
        int vd0;
        @(posedge iSysClk);
        run <= 1'b0;
        pixTick <= 1'b1;
        // drain whatever is buffered
        repeat (20) @(posedge iSysClk);
        pixTick <= 1'b0;
        repeat (3) @(posedge iSysClk);
        under0 = underCount;
        vd0 = pixCount;
        repeat (5)
        begin
            pixTick <= 1'b1;
            @(posedge iSysClk);
            pixTick <= 1'b0;
            repeat (2) @(posedge iSysClk);
        end
        repeat (2) @(posedge iSysClk);
        checkEq(32'(underCount - under0), 5, "underrun pulses on empty ticks");
        checkEq(32'(pixCount - vd0), 0, "dots while drained");
        // restart and let the model check the order
        run <= 1'b1;
        pixTick <= 1'b1;
        waitPixels(64);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial
    begin
        rstN = 1'b0;
        run = 1'b0;
        pixTick = 1'b0;
        testReset();
        testFrames();
        testToggle();
        testBackPressure();
        testUnderrun();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog allows 20 cycles per dot plus reset slack
    initial
    begin
        repeat (lpTotalPix * 20 + 200) @(posedge iSysClk);
        $display("watchdog expired, tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/dotGenPkg.sv
verilog/scanPosGen.sv
verilog/dotPainter.sv
verilog/pixelFifo.sv
verilog/scanOut.sv
verilog/dotGenTop.sv
verif/dotGenTb.sv

// File: Makefile
TOP := dotGenTb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 ; cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
